// File: src/pixelPkg.sv
package pixelPkg;

  // ------------------------------------------------------------
  // Frame buffer sizing
  // ------------------------------------------------------------

  // Maximum address width; a 32x32 frame
  // The top level may only shrink the used depth below this
  parameter int addrW = 10;

  parameter int colorW = 8; // One byte per pixel

  // Default number of drawing engine ports
  parameter int numPorts = 8;

  // ------------------------------------------------------------
  // Payload structs
  // ------------------------------------------------------------

  // Engine write, 18 bits
  typedef struct packed {
    logic [addrW-1:0]  addr;
    logic [colorW-1:0] color;
  } pixelWrite_t;

  // Reader request
  typedef struct packed {
    logic [addrW-1:0] addr;
  } pixelRead_t;

  // Read response, address echoed back with the colour
  typedef struct packed {
    logic [addrW-1:0]  addr;
    logic [colorW-1:0] color;
  } pixelResp_t;

endpackage

// File: src/pixelArbiter.sv
module pixelArbiter #(
  parameter int NumPorts = pixelPkg::numPorts
) (
  input  logic                                   clk,
  input  logic                                   arstN,

  // Engine side
  input  logic                    [NumPorts-1:0] reqValid,
  input  pixelPkg::pixelWrite_t   [NumPorts-1:0] req,
  output logic                    [NumPorts-1:0] reqReady,

  // Registered output stage
  output logic                                   outValid,
  output pixelPkg::pixelWrite_t                  out,
  input  logic                                   outReady
);

  localparam int IdxW = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  // ------------------------------------------------------------
  // Priority select, highest index wins
  // ------------------------------------------------------------

  logic [NumPorts-1:0] grant;    // One-hot
  logic [IdxW-1:0]     grantIdx;
  logic                anyValid;
  logic                outFree;  // Output register empty or draining
  logic                loadOut;

  always_comb begin
    grant    = '0;
    grantIdx = '0;
    anyValid = 1'b0;
    // Ascending scan, so the last hit is the highest port
    for (int i = 0; i < NumPorts; i++) begin
      if (reqValid[i]) begin
        grant    = '0;
        grant[i] = 1'b1;
        grantIdx = IdxW'(i);
        anyValid = 1'b1;
      end
    end
  end

  assign outFree  = !outValid || outReady;
  assign loadOut  = outFree && anyValid;

  // No port sees ready while the output stage is stalled
  assign reqReady = outFree ? grant : '0;

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else if (outFree) begin
      outValid <= anyValid; // Refill or go empty
    end
  end

  always_ff @(posedge clk) begin
    if (loadOut) begin
      out <= req[grantIdx]; // Winner's payload
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // At most one engine handshakes per cycle
  assert property (@(posedge clk) disable iff (!arstN)
    $onehot0(reqReady))
    else $error("arbiter granted more than one port: %h", reqReady);

  // Stalled output holds its pixel until the skid takes it
  assert property (@(posedge clk) disable iff (!arstN)
    outValid && !outReady |=> outValid && $stable(out))
    else $error("arbiter output changed under back-pressure");

endmodule

// File: src/pipeSkid.sv
module pipeSkid #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     arstN,

  input  logic     inValid,
  input  payload_t inData,
  output logic     inReady,   // Registered, from occupancy only

  output logic     outValid,
  output payload_t outData,
  input  logic     outReady
);

  logic     skidValid;
  payload_t skidData;

  logic inFire;
  logic mainFree;   // Main register empty or draining this cycle
  logic loadMain;
  logic loadSkid;
  logic mainValidNext;
  logic skidValidNext;

  // ------------------------------------------------------------
  // Occupancy
  // ------------------------------------------------------------

  assign inFire   = inValid && inReady;
  assign mainFree = !outValid || outReady;

  // Skid drains into main first, new input goes to main only if skid is empty
  assign loadMain = mainFree && (skidValid || inFire);
  assign loadSkid = !mainFree && inFire;

  always_comb begin
    mainValidNext = outValid;
    skidValidNext = skidValid;
    if (mainFree) begin
      mainValidNext = skidValid || inFire;
      skidValidNext = 1'b0;
    end else if (inFire) begin
      skidValidNext = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid  <= 1'b0;
      skidValid <= 1'b0;
      inReady   <= 1'b0;
    end else begin
      outValid  <= mainValidNext;
      skidValid <= skidValidNext;
      inReady   <= !skidValidNext; // Room left for one more
    end
  end

  // ------------------------------------------------------------
  // Data path
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (loadMain) begin
      outData <= skidValid ? skidData : inData;
    end
    if (loadSkid) begin
      skidData <= inData;
    end
  end

  // Registered ready must never let an item land on a full skid
  assert property (@(posedge clk) disable iff (!arstN)
    loadSkid |-> !skidValid)
    else $error("skid register overwritten, accepted item lost");

endmodule

// File: src/frameBuffer.sv
module frameBuffer #(
  parameter int AddrW = pixelPkg::addrW // At most pixelPkg::addrW
) (
  input  logic                  clk,
  input  logic                  arstN,

  // Write port, never refuses
  input  logic                  wrValid,
  input  pixelPkg::pixelWrite_t wr,

  // Read request port
  input  logic                  rdValid,
  input  pixelPkg::pixelRead_t  rd,
  output logic                  rdReady,

  // Read response
  output logic                  respValid,
  output pixelPkg::pixelResp_t  resp,
  input  logic                  respReady
);

  localparam int Depth = 1 << AddrW;

  logic [pixelPkg::colorW-1:0] mem [Depth];

  logic             rdFire;
  logic [AddrW-1:0] wrIdx;
  logic [AddrW-1:0] rdIdx;

  assign wrIdx = wr.addr[AddrW-1:0];
  assign rdIdx = rd.addr[AddrW-1:0];

  // ------------------------------------------------------------
  // Write side
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrIdx] <= wr.color;
    end
  end

  // ------------------------------------------------------------
  // Read side
  // ------------------------------------------------------------

  // New request only when the response slot frees up
  assign rdReady = !respValid || respReady;
  assign rdFire  = rdValid && rdReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      respValid <= 1'b0;
    end else if (rdFire) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;
    end
  end

  // Read-first, a same-edge write is seen by the next read
  always_ff @(posedge clk) begin
    if (rdFire) begin
      resp.addr  <= rd.addr;
      resp.color <= mem[rdIdx];
    end
  end

  // Engines must stay inside the configured frame
  assert property (@(posedge clk) disable iff (!arstN)
    wrValid |-> (int'(wr.addr) < Depth))
    else $error("write address %h outside frame depth %0d", wr.addr, Depth);

endmodule

// File: src/pixelSubsystem.sv
module pixelSubsystem #(
  parameter int NumPorts = pixelPkg::numPorts,
  parameter int AddrW    = pixelPkg::addrW
) (
  input  logic                                 clk,
  input  logic                                 arstN,

  // Drawing engines
  input  logic                  [NumPorts-1:0] wrValid,
  input  pixelPkg::pixelWrite_t [NumPorts-1:0] wrReq,
  output logic                  [NumPorts-1:0] wrReady,

  // Reader requests
  input  logic                                 rdValid,
  input  pixelPkg::pixelRead_t                 rdReq,
  output logic                                 rdReady,

  // Reader responses
  output logic                                 respValid,
  output pixelPkg::pixelResp_t                 resp,
  input  logic                                 respReady
);

  // ------------------------------------------------------------
  // Write path wires
  // ------------------------------------------------------------

  logic                  arbValid;
  pixelPkg::pixelWrite_t arbData;
  logic                  arbReady;

  logic                  fbWrValid;
  pixelPkg::pixelWrite_t fbWr;

  // ------------------------------------------------------------
  // Read path wires
  // ------------------------------------------------------------

  logic                  fbRdValid;
  pixelPkg::pixelRead_t  fbRd;
  logic                  fbRdReady;

  pixelArbiter #(
    .NumPorts (NumPorts)
  ) u_arbiter (
    .clk      (clk),
    .arstN    (arstN),
    .reqValid (wrValid),
    .req      (wrReq),
    .reqReady (wrReady),
    .outValid (arbValid),
    .out      (arbData),
    .outReady (arbReady)
  );

  pipeSkid #(
    .payload_t (pixelPkg::pixelWrite_t)
  ) u_wrSkid (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (arbValid),
    .inData   (arbData),
    .inReady  (arbReady),
    .outValid (fbWrValid),
    .outData  (fbWr),
    .outReady (1'b1)      // Memory always takes writes
  );

  pipeSkid #(
    .payload_t (pixelPkg::pixelRead_t)
  ) u_rdSkid (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (rdValid),
    .inData   (rdReq),
    .inReady  (rdReady),
    .outValid (fbRdValid),
    .outData  (fbRd),
    .outReady (fbRdReady)
  );

  frameBuffer #(
    .AddrW (AddrW)
  ) u_frameBuffer (
    .clk       (clk),
    .arstN     (arstN),
    .wrValid   (fbWrValid),
    .wr        (fbWr),
    .rdValid   (fbRdValid),
    .rd        (fbRd),
    .rdReady   (fbRdReady),
    .respValid (respValid),
    .resp      (resp),
    .respReady (respReady)
  );

endmodule

// File: dv/pixelSubsystemTb.sv
module pixelSubsystemTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumPorts  = pixelPkg::numPorts;
  localparam int AddrW     = pixelPkg::addrW;
  localparam int ColorW    = pixelPkg::colorW;
  localparam int IdxW      = (NumPorts > 1) ? $clog2(NumPorts) : 1;
  localparam int WrLatency = 3;   // Arbiter register, skid, memory write
  localparam int WaitLimit = 100; // Cycles allowed per wait loop

  logic                                 clk;
  logic                                 arstN;
  logic                  [NumPorts-1:0] wrValid;
  pixelPkg::pixelWrite_t [NumPorts-1:0] wrReq;
  logic                  [NumPorts-1:0] wrReady;
  logic                                 rdValid;
  pixelPkg::pixelRead_t                 rdReq;
  logic                                 rdReady;
  logic                                 respValid;
  pixelPkg::pixelResp_t                 resp;
  logic                                 respReady;

  logic stallResp; // Random respReady gaps when set

  logic [ColorW-1:0]    shadowMem [int];
  pixelPkg::pixelResp_t expQ [$];
  int                   knownAddr [$];

  int ctrlMismatches = 0;
  int respMismatches = 0;
  int timeoutCount   = 0;
  int protocolCount  = 0;
  int respCount      = 0;

  pixelSubsystem #(
    .NumPorts (NumPorts),
    .AddrW    (AddrW)
  ) u_pixelSubsystem (
    .clk       (clk),
    .arstN     (arstN),
    .wrValid   (wrValid),
    .wrReq     (wrReq),
    .wrReady   (wrReady),
    .rdValid   (rdValid),
    .rdReq     (rdReq),
    .rdReady   (rdReady),
    .respValid (respValid),
    .resp      (resp),
    .respReady (respReady)
  );

  initial begin : clockGen
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Reference model and compare tasks
  // ------------------------------------------------------------

  // Highest-numbered requesting engine wins
  function automatic int expectedWinner(input logic [NumPorts-1:0] vec);
    for (int i = NumPorts - 1; i >= 0; i--) begin
      if (vec[IdxW'(i)]) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      ctrlMismatches++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkGrant(input string name, input logic [NumPorts-1:0] got,
                            input logic [NumPorts-1:0] exp);
    if (got !== exp) begin
      ctrlMismatches++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkResp(input string name, input pixelPkg::pixelResp_t got,
                           input pixelPkg::pixelResp_t exp);
    if (got !== exp) begin
      respMismatches++;
      $display("mismatch %s: got addr %h color %h expected addr %h color %h",
               name, got.addr, got.color, exp.addr, exp.color);
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus tasks enter and leave 2 ns after a rising edge
  // ------------------------------------------------------------

  task automatic writeBurst(input logic [NumPorts-1:0] vec);
    logic [NumPorts-1:0] pending;
    logic [NumPorts-1:0] granted;
    logic [NumPorts-1:0] winMask;
    logic [IdxW-1:0]     winIdx;
    int                  winner;
    int                  cycles;
    pending = vec;
    cycles  = 0;
    wrValid = pending;
    while (pending != '0 && cycles < WaitLimit) begin
      @(negedge clk);
      winner  = expectedWinner(pending);
      winMask = NumPorts'(1) << winner;
      winIdx  = IdxW'(winner);
      granted = wrReady;
      checkGrant("wrReady", granted, winMask);
      if ((granted & winMask) != '0) begin
        shadowMem[int'(wrReq[winIdx].addr)] = wrReq[winIdx].color; // Grant order
      end
      @(posedge clk);
      #2;
      pending = pending & ~granted; // Accepted ports drop valid
      wrValid = pending;
      cycles++;
    end
    if (pending != '0) begin
      timeoutCount++;
      $display("timeout: engine ports %h never got wrReady within %0d cycles",
               pending, WaitLimit);
      wrValid = '0;
    end
  endtask

  task automatic readPixel(input logic [AddrW-1:0] addr, input logic [ColorW-1:0] color);
    pixelPkg::pixelResp_t expResp;
    logic                 accepted;
    int                   cycles;
    accepted   = 1'b0;
    cycles     = 0;
    rdValid    = 1'b1;
    rdReq.addr = addr;
    while (!accepted && cycles < WaitLimit) begin
      @(negedge clk);
      accepted = rdReady;
      @(posedge clk);
      #2;
      cycles++;
    end
    rdValid = 1'b0;
    if (accepted) begin
      expResp.addr  = addr;
      expResp.color = color;
      expQ.push_back(expResp);
    end else begin
      timeoutCount++;
      $display("timeout: read of address %h never accepted within %0d cycles",
               addr, WaitLimit);
    end
  endtask

  // Last accepted write reaches memory
  task automatic drainWrites();
    repeat (WrLatency) @(posedge clk);
    #2;
  endtask

  task automatic waitResponses();
    int cycles;
    cycles = 0;
    while (expQ.size() != 0 && cycles < WaitLimit) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (expQ.size() != 0) begin
      timeoutCount++;
      $display("timeout: %0d read responses still missing after %0d cycles",
               expQ.size(), WaitLimit);
      expQ.delete();
    end
  endtask

  // ------------------------------------------------------------
  // Response side
  // ------------------------------------------------------------

  initial begin : respReadyDriver
    respReady = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      if (stallResp) begin
        respReady = ($urandom_range(2) != 0); // Low about a third of cycles
      end else begin
        respReady = 1'b1;
      end
    end
  end

  initial begin : respMonitor
    pixelPkg::pixelResp_t held;
    pixelPkg::pixelResp_t expResp;
    logic                 holding;
    holding = 1'b0;
    forever begin
      @(negedge clk);
      if (arstN === 1'b1 && respValid === 1'b1) begin
        if (holding) begin
          checkResp("resp (held)", resp, held);
        end
        if (respReady) begin
          if (expQ.size() == 0) begin
            protocolCount++;
            $display("response for address %h arrived with no read outstanding", resp.addr);
          end else begin
            expResp = expQ.pop_front();
            checkResp("resp", resp, expResp);
            respCount++;
          end
          holding = 1'b0;
        end else begin
          held    = resp;
          holding = 1'b1;
        end
      end else begin
        if (holding) begin
          protocolCount++;
          $display("respValid dropped before the held response was taken");
        end
        holding = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin : mainSeq
    logic [NumPorts-1:0] vec;
    logic [AddrW-1:0]    addrList [$];
    logic [AddrW-1:0]    sameAddr;
    logic [IdxW-1:0]     idx;
    int                  pick;
    void'($urandom(32'hed6b_db7b));
    arstN     = 1'b0;
    wrValid   = '0;
    wrReq     = '0;
    rdValid   = 1'b0;
    rdReq     = '0;
    stallResp = 1'b0;

    // Everything quiet in and right after reset
    @(posedge clk);
    @(negedge clk);
    checkBit("wrReady (any)", |wrReady, 1'b0);
    checkBit("rdReady", rdReady, 1'b0);
    checkBit("respValid", respValid, 1'b0);
    repeat (2) @(posedge clk);
    #2;
    arstN = 1'b1;
    @(negedge clk);
    checkBit("wrReady (any)", |wrReady, 1'b0);
    checkBit("rdReady", rdReady, 1'b0);
    checkBit("respValid", respValid, 1'b0);
    @(posedge clk);
    #2;

    // Single-port writes to distinct addresses, then read back
    for (int k = 0; k < 8; k++) begin
      idx = IdxW'(k % NumPorts);
      addrList.push_back(AddrW'(37 * k + 5));
      wrReq[idx].addr  = addrList[k];
      wrReq[idx].color = ColorW'(8'h11 * (k + 1));
      writeBurst(NumPorts'(1) << (k % NumPorts));
    end
    drainWrites();
    foreach (addrList[k]) begin
      readPixel(addrList[k], shadowMem[int'(addrList[k])]);
    end
    waitResponses();

    // All engines hit one pixel at once
    sameAddr = AddrW'('h155);
    for (int p = 0; p < NumPorts; p++) begin
      idx = IdxW'(p);
      wrReq[idx].addr  = sameAddr;
      wrReq[idx].color = ColorW'(8'hA0 + p);
    end
    writeBurst('1);
    drainWrites();
    readPixel(sameAddr, wrReq[0].color); // Port 0 is granted last
    waitResponses();

    // Random valid vectors over a small window of addresses
    for (int r = 0; r < 40; r++) begin
      for (int p = 0; p < NumPorts; p++) begin
        idx = IdxW'(p);
        wrReq[idx].addr  = AddrW'($urandom_range(63));
        wrReq[idx].color = ColorW'($urandom);
      end
      vec = NumPorts'($urandom);
      if (vec == '0) begin
        vec = NumPorts'(1);
      end
      writeBurst(vec);
    end
    drainWrites();
    foreach (shadowMem[a]) begin
      knownAddr.push_back(a);
      readPixel(AddrW'(a), shadowMem[a]);
    end
    waitResponses();

    // Read stream under random back-pressure
    stallResp = 1'b1;
    for (int n = 0; n < 60; n++) begin
      pick = knownAddr[$urandom_range(knownAddr.size() - 1)];
      readPixel(AddrW'(pick), shadowMem[pick]);
    end
    waitResponses();
    stallResp = 1'b0;

    $display("errors: %0d control, %0d response, %0d timeout, %0d protocol (%0d responses)",
             ctrlMismatches, respMismatches, timeoutCount, protocolCount, respCount);
    if (ctrlMismatches + respMismatches + timeoutCount + protocolCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
src/pixelPkg.sv
src/pixelArbiter.sv
src/pipeSkid.sv
src/frameBuffer.sv
src/pixelSubsystem.sv
dv/pixelSubsystemTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the pixel subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=pixelSubsystemTb
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module "$TOP" -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$("./$OBJ/V$TOP" 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
